// ==== hw/exit_pkg.sv ====
package exit_pkg;

  // Bus address and data are fixed at 32 bits.
  // One byte address on the AXI4-Lite bus.
  typedef logic [31:0] addr_t;

  // One bus data word, also used for the exit code.
  typedef logic [31:0] data_t;

  // Single-cycle memory request issued by the bridge.
  // The req field is a strobe that is high for exactly one cycle.
  typedef struct packed {
    logic  req;
    logic  we;
    addr_t addr;
    data_t wdata;
  } mem_req_t;

  // Exit event from the decoder into the status block.
  // The code is zero for a write to the exit-with-zero offset.
  typedef struct packed {
    logic  valid;
    data_t code;
  } exit_evt_t;

  // Register offsets inside the device.
  // Writing here ends the run with the written word.
  localparam logic [7:0] EXIT_CODE_OFS = 8'h04;
  // Writing here ends the run with code zero, whatever the data.
  localparam logic [7:0] EXIT_ZERO_OFS = 8'h10;

  // Write path states of the AXI4-Lite bridge.
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    REQ  = 2'd1,
    RESP = 2'd2
  } bridge_state_e;

endpackage

// ==== hw/axi_lite_mem_bridge.sv ====
`timescale 1ns/1ps

module axi_lite_mem_bridge (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Write address channel.
  input  logic               awvalid_i,
  input  exit_pkg::addr_t    awaddr_i,
  output logic               awready_o,
  // Write data channel.
  input  logic               wvalid_i,
  input  exit_pkg::data_t    wdata_i,
  output logic               wready_o,
  // Write response channel with OKAY responses only.
  output logic               bvalid_o,
  input  logic               bready_i,
  // Read address channel.
  input  logic               arvalid_i,
  input  exit_pkg::addr_t    araddr_i,
  output logic               arready_o,
  // Read data channel with OKAY responses only.
  output logic               rvalid_o,
  output exit_pkg::data_t    rdata_o,
  input  logic               rready_i,
  // Memory side.
  output exit_pkg::mem_req_t req_o,
  output exit_pkg::addr_t    rd_addr_o,
  input  exit_pkg::data_t    rd_data_i
);

  // Write state machine.
  exit_pkg::bridge_state_e state_q;
  exit_pkg::bridge_state_e state_d;

  // Write address and data held from the handshake until the strobe.
  exit_pkg::addr_t waddr_q;
  exit_pkg::data_t wdata_q;

  // Handshake qualifiers.
  logic aw_w_hs;
  logic ar_hs;

  // Read response register.
  logic            rvalid_q;
  exit_pkg::data_t rdata_q;

  // AW and W are taken together, and only when both are offered.
  // Nothing is accepted while a write is in flight or a B is pending.
  assign aw_w_hs   = (state_q == exit_pkg::IDLE) && awvalid_i && wvalid_i;
  assign awready_o = aw_w_hs;
  assign wready_o  = aw_w_hs;

  // Next-state logic of the write path.
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      exit_pkg::IDLE: begin
        // Both channels handshake on this edge.
        if (aw_w_hs) begin
          state_d = exit_pkg::REQ;
        end
      end
      exit_pkg::REQ: begin
        // Strobe lasts one cycle only.
        state_d = exit_pkg::RESP;
      end
      exit_pkg::RESP: begin
        // Hold the response until the master takes it.
        if (bready_i) begin
          state_d = exit_pkg::IDLE;
        end
      end
      default: begin
        state_d = exit_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= exit_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Capture address and data on the handshake edge.
  always_ff @(posedge clk_i) begin
    if (aw_w_hs) begin
      waddr_q <= awaddr_i;
      wdata_q <= wdata_i;
    end
  end

  // One write request per accepted write, issued from REQ.
  always_comb begin
    req_o.req   = (state_q == exit_pkg::REQ);
    req_o.we    = (state_q == exit_pkg::REQ);
    req_o.addr  = waddr_q;
    req_o.wdata = wdata_q;
  end

  // B is pending for the whole RESP state.
  assign bvalid_o = (state_q == exit_pkg::RESP);

  // Only one read is outstanding at a time.
  assign arready_o = !rvalid_q;
  assign ar_hs     = arvalid_i && arready_o;

  // The status block decodes the AR address combinationally.
  assign rd_addr_o = araddr_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else if (ar_hs) begin
      rvalid_q <= 1'b1;
    end else if (rready_i) begin
      // Response consumed.
      rvalid_q <= 1'b0;
    end
  end

  // Read data is sampled on the AR edge and held while R waits.
  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      rdata_q <= rd_data_i;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

  // A B response, once offered, stays up until the master accepts it.
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    bvalid_o && !bready_i |=> bvalid_o)
    else $error("bvalid dropped before bready");

  // Each strobe follows an accepted write and carries its address and data.
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_o.req |-> $past(aw_w_hs) && (req_o.addr == $past(awaddr_i))
      && (req_o.wdata == $past(wdata_i)))
    else $error("request strobe without a matching write handshake");

endmodule

// ==== hw/exit_decoder.sv ====
`timescale 1ns/1ps

module exit_decoder #(
  parameter int unsigned DECODE_BITS = 8
) (
  input  exit_pkg::mem_req_t  req_i,
  output exit_pkg::exit_evt_t evt_o
);

  // The offsets need at least 8 bits, and the address has 32.
  if (DECODE_BITS < 8 || DECODE_BITS > 32) begin : g_bad_decode_bits
    $error("DECODE_BITS must lie between 8 and 32");
  end

  // Low address bits that select a register.
  logic [DECODE_BITS-1:0] ofs;

  // Write strobe qualifier.
  logic wr;

  // Offset matches.
  logic hit_code;
  logic hit_zero;

  assign wr  = req_i.req && req_i.we;
  assign ofs = req_i.addr[DECODE_BITS-1:0];

  // Offsets are zero-extended, so upper decoded bits must be clear.
  assign hit_code = (ofs == DECODE_BITS'(exit_pkg::EXIT_CODE_OFS));
  assign hit_zero = (ofs == DECODE_BITS'(exit_pkg::EXIT_ZERO_OFS));

  always_comb begin
    evt_o.valid = wr && (hit_code || hit_zero);
    // Exit-with-zero ignores the written data.
    if (wr && hit_code) begin
      evt_o.code = req_i.wdata;
    end else begin
      evt_o.code = '0;
    end
  end

  // Reads never end the run.
  always_comb begin
    assert #0 (!evt_o.valid || (req_i.req && req_i.we))
      else $error("exit event without a write request");
  end

endmodule

// ==== hw/exit_status.sv ====
`timescale 1ns/1ps

module exit_status (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Exit event from the decoder.
  input  exit_pkg::exit_evt_t evt_i,
  // Read-back port.
  input  exit_pkg::addr_t     rd_addr_i,
  output exit_pkg::data_t     rd_data_o,
  // Exit outputs to the simulation environment.
  output logic                exit_valid_o,
  output logic                exit_zero_o,
  output exit_pkg::data_t     exit_code_o
);

  // Width of the register offsets.
  localparam int unsigned ofs_bits = $bits(exit_pkg::EXIT_CODE_OFS);

  // Code is zero for an exit-with-zero event too.
  logic code_is_zero;

  assign code_is_zero = (evt_i.code == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exit_valid_o <= 1'b0;
      exit_zero_o  <= 1'b0;
      exit_code_o  <= '0;
    end else if (evt_i.valid) begin
      // Sticky until reset.
      exit_valid_o <= 1'b1;
      // Flag and code track the latest event.
      exit_zero_o  <= code_is_zero;
      exit_code_o  <= evt_i.code;
    end
  end

  // Only the exit-code register reads back. Other offsets give zero.
  always_comb begin
    if (rd_addr_i[ofs_bits-1:0] == exit_pkg::EXIT_CODE_OFS) begin
      rd_data_o = exit_code_o;
    end else begin
      rd_data_o = '0;
    end
  end

  // Once the run has ended, it stays ended.
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    exit_valid_o |=> exit_valid_o)
    else $error("exit_valid_o fell without reset");

endmodule

// ==== hw/exit_device_top.sv ====
`timescale 1ns/1ps

module exit_device_top #(
  parameter int unsigned DECODE_BITS = 8
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  // AXI4-Lite slave port.
  input  logic            awvalid_i,
  input  exit_pkg::addr_t awaddr_i,
  output logic            awready_o,
  input  logic            wvalid_i,
  input  exit_pkg::data_t wdata_i,
  output logic            wready_o,
  output logic            bvalid_o,
  input  logic            bready_i,
  input  logic            arvalid_i,
  input  exit_pkg::addr_t araddr_i,
  output logic            arready_o,
  output logic            rvalid_o,
  output exit_pkg::data_t rdata_o,
  input  logic            rready_i,
  // Exit outputs.
  output logic            exit_valid_o,
  output logic            exit_zero_o,
  output exit_pkg::data_t exit_code_o
);

  // Write strobe from the bridge.
  exit_pkg::mem_req_t  mem_req;
  // Decoded exit event.
  exit_pkg::exit_evt_t exit_evt;
  // Combinational read path.
  exit_pkg::addr_t     rd_addr;
  exit_pkg::data_t     rd_data;

  axi_lite_mem_bridge u_bridge (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .awvalid_i (awvalid_i),
    .awaddr_i  (awaddr_i),
    .awready_o (awready_o),
    .wvalid_i  (wvalid_i),
    .wdata_i   (wdata_i),
    .wready_o  (wready_o),
    .bvalid_o  (bvalid_o),
    .bready_i  (bready_i),
    .arvalid_i (arvalid_i),
    .araddr_i  (araddr_i),
    .arready_o (arready_o),
    .rvalid_o  (rvalid_o),
    .rdata_o   (rdata_o),
    .rready_i  (rready_i),
    .req_o     (mem_req),
    .rd_addr_o (rd_addr),
    .rd_data_i (rd_data)
  );

  exit_decoder #(
    .DECODE_BITS (DECODE_BITS)
  ) u_decoder (
    .req_i (mem_req),
    .evt_o (exit_evt)
  );

  exit_status u_status (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .evt_i        (exit_evt),
    .rd_addr_i    (rd_addr),
    .rd_data_o    (rd_data),
    .exit_valid_o (exit_valid_o),
    .exit_zero_o  (exit_zero_o),
    .exit_code_o  (exit_code_o)
  );

endmodule

// ==== tests/tb_exit_device.sv ====
`timescale 1ns/1ps

module tb_exit_device;

  // Data file path relative to the project root.
  localparam string TESTDATA_FILE = "tests/exit_testdata.txt";
  // Upper bound in clock cycles for any single handshake.
  localparam int TIMEOUT_CYCLES = 50;
  // Seed for the back-pressure delays.
  localparam logic [31:0] SEED = 32'd47716;

  logic            clk;
  logic            rst_n;
  logic            awvalid;
  exit_pkg::addr_t awaddr;
  logic            awready;
  logic            wvalid;
  exit_pkg::data_t wdata;
  logic            wready;
  logic            bvalid;
  logic            bready;
  logic            arvalid;
  exit_pkg::addr_t araddr;
  logic            arready;
  logic            rvalid;
  exit_pkg::data_t rdata;
  logic            rready;
  logic            exit_valid;
  logic            exit_zero;
  exit_pkg::data_t exit_code;

  // Xorshift state for the random delays.
  logic [31:0] rng_state;
  // B responses offered on the bus.
  int b_count;
  // bvalid as seen on the previous rising edge.
  logic bvalid_prev;

  exit_device_top #(
    .DECODE_BITS (8)
  ) dut (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .awvalid_i    (awvalid),
    .awaddr_i     (awaddr),
    .awready_o    (awready),
    .wvalid_i     (wvalid),
    .wdata_i      (wdata),
    .wready_o     (wready),
    .bvalid_o     (bvalid),
    .bready_i     (bready),
    .arvalid_i    (arvalid),
    .araddr_i     (araddr),
    .arready_o    (arready),
    .rvalid_o     (rvalid),
    .rdata_o      (rdata),
    .rready_i     (rready),
    .exit_valid_o (exit_valid),
    .exit_zero_o  (exit_zero),
    .exit_code_o  (exit_code)
  );

  // 20 ns clock.
  always #10 clk = ~clk;

  // Count every B response offered, so an extra one shows up.
  always @(posedge clk) begin
    if (bvalid && !bvalid_prev) begin
      b_count <= b_count + 1;
    end
    bvalid_prev <= bvalid;
  end

  // Print the reason, then the fail message, and stop.
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("FAIL %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_word(input string name, input exit_pkg::data_t exp,
                            input exit_pkg::data_t act);
    if (act !== exp) begin
      abort_run($sformatf("FAIL %s expected %h actual %h", name, exp, act));
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Back-pressure delay of 0 to 3 cycles.
  task automatic pick_delay(output int delay);
    rng_state = xorshift32(rng_state);
    delay = int'(rng_state[1:0]);
  endtask

  // Starts and ends on a falling edge.
  task automatic write_word(input exit_pkg::addr_t addr, input exit_pkg::data_t data);
    int cycles;
    int delay;
    awvalid = 1'b1;
    awaddr  = addr;
    wvalid  = 1'b1;
    wdata   = data;
    // AW and W must be taken on the same edge.
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (!(awready && wready) && cycles >= TIMEOUT_CYCLES) begin
        abort_run("AW/W handshake did not complete");
      end
    end while (!(awready && wready));
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    // The request strobe cycle comes first, then B.
    check_bit("bvalid_o", 1'b0, bvalid);
    @(negedge clk);
    check_bit("bvalid_o", 1'b1, bvalid);
    pick_delay(delay);
    repeat (delay) @(negedge clk);
    // B holds while bready stays low.
    check_bit("bvalid_o", 1'b1, bvalid);
    bready = 1'b1;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (!bvalid && cycles >= TIMEOUT_CYCLES) begin
        abort_run("B handshake did not complete");
      end
    end while (!bvalid);
    @(negedge clk);
    bready = 1'b0;
    check_bit("bvalid_o", 1'b0, bvalid);
  endtask

  // Starts and ends on a falling edge.
  task automatic read_word(input exit_pkg::addr_t addr, input exit_pkg::data_t exp_data);
    int cycles;
    int delay;
    exit_pkg::data_t got;
    arvalid = 1'b1;
    araddr  = addr;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (!arready && cycles >= TIMEOUT_CYCLES) begin
        abort_run("AR handshake did not complete");
      end
    end while (!arready);
    @(negedge clk);
    arvalid = 1'b0;
    // R follows the AR edge by one cycle.
    check_bit("rvalid_o", 1'b1, rvalid);
    pick_delay(delay);
    repeat (delay) @(negedge clk);
    rready = 1'b1;
    cycles = 0;
    do begin
      @(posedge clk);
      got = rdata;
      cycles++;
      if (!rvalid && cycles >= TIMEOUT_CYCLES) begin
        abort_run("R handshake did not complete");
      end
    end while (!rvalid);
    @(negedge clk);
    rready = 1'b0;
    check_bit("rvalid_o", 1'b0, rvalid);
    check_word("rdata_o", exp_data, got);
  endtask

  initial begin
    int              fd;
    int              rc;
    int              n;
    int              ops_done;
    int              writes_done;
    string           line;
    string           op;
    exit_pkg::addr_t addr;
    exit_pkg::data_t data;
    logic            exp_valid;
    logic            exp_zero;
    exit_pkg::data_t exp_code;
    exit_pkg::data_t exp_rdata;
    clk         = 1'b0;
    rst_n       = 1'b0;
    awvalid     = 1'b0;
    awaddr      = '0;
    wvalid      = 1'b0;
    wdata       = '0;
    bready      = 1'b0;
    arvalid     = 1'b0;
    araddr      = '0;
    rready      = 1'b0;
    rng_state   = SEED;
    b_count     = 0;
    bvalid_prev = 1'b0;
    ops_done    = 0;
    writes_done = 0;
    // Three rising edges in reset.
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_bit("awready_o", 1'b0, awready);
    check_bit("wready_o", 1'b0, wready);
    check_bit("bvalid_o", 1'b0, bvalid);
    check_bit("rvalid_o", 1'b0, rvalid);
    check_bit("arready_o", 1'b1, arready);
    check_bit("exit_valid_o", 1'b0, exit_valid);
    check_bit("exit_zero_o", 1'b0, exit_zero);
    fd = $fopen(TESTDATA_FILE, "r");
    if (fd == 0) begin
      abort_run("could not open the data file");
    end
    while (!$feof(fd)) begin
      line = "";
      rc = $fgets(line, fd);
      // Skip comments and blank lines.
      if (rc == 0 || line.len() == 0) continue;
      if (line[0] == "#" || line[0] == "\n") continue;
      n = $sscanf(line, "%s %h %h %h %h %h %h", op, addr, data,
                  exp_valid, exp_zero, exp_code, exp_rdata);
      if (n != 7) begin
        abort_run($sformatf("malformed data line: %s", line));
      end
      if (op == "W") begin
        write_word(addr, data);
        writes_done++;
      end else if (op == "R") begin
        read_word(addr, exp_rdata);
      end else begin
        abort_run($sformatf("unknown operation in data line: %s", line));
      end
      // Exit outputs have settled by the end of every operation.
      check_bit("exit_valid_o", exp_valid, exit_valid);
      check_bit("exit_zero_o", exp_zero, exit_zero);
      check_word("exit_code_o", exp_code, exit_code);
      // Each write so far got exactly one B response.
      if (b_count != writes_done) begin
        abort_run($sformatf("%0d B responses offered for %0d writes",
                            b_count, writes_done));
      end
      ops_done++;
    end
    $fclose(fd);
    if (ops_done == 0) begin
      abort_run("the data file held no operations");
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

// ==== tests/exit_testdata.txt ====
# Columns: op addr data exp_exit_valid exp_exit_zero exp_exit_code exp_rdata
# op is W or R; data is unused for reads and exp_rdata is unused for writes.
# Reset state reads back zero.
R 00000004 00000000 0 0 00000000 00000000
R 00000010 00000000 0 0 00000000 00000000
# Other offsets, and offsets matching only above the low byte, are ignored.
W 00000008 12345678 0 0 00000000 00000000
W 00000400 12345678 0 0 00000000 00000000
W 00001000 12345678 0 0 00000000 00000000
W 00040000 12345678 0 0 00000000 00000000
W 00000005 12345678 0 0 00000000 00000000
R 00000008 00000000 0 0 00000000 00000000
# Exit with a nonzero code and read it back.
W 00000004 0000002a 1 0 0000002a 00000000
R 00000004 00000000 1 0 0000002a 0000002a
# Once set, other offsets leave the exit outputs alone.
W 00000400 ffffffff 1 0 0000002a 00000000
W 00000014 ffffffff 1 0 0000002a 00000000
W 00100000 ffffffff 1 0 0000002a 00000000
W 00000000 ffffffff 1 0 0000002a 00000000
R 00000010 00000000 1 0 0000002a 00000000
# Exit with zero ignores the data word.
W 00000010 cafef00d 1 1 00000000 00000000
R 00000004 00000000 1 1 00000000 00000000
# Back-to-back writes, applied in order.
W 00000004 00000001 1 0 00000001 00000000
W 00000004 00000002 1 0 00000002 00000000
W 00000010 00000055 1 1 00000000 00000000
W 00000004 80000000 1 0 80000000 00000000
W 00000004 fffffffe 1 0 fffffffe 00000000
R 00000004 00000000 1 0 fffffffe fffffffe
# A zero code written to 0x04 sets the zero flag.
W 00000004 00000000 1 1 00000000 00000000
R 00000000 00000000 1 1 00000000 00000000
R 0000000c 00000000 1 1 00000000 00000000
R 00000010 00000000 1 1 00000000 00000000
# Reads away from 0x04 stay zero with a nonzero code.
W 00000004 0badc0de 1 0 0badc0de 00000000
R 00000008 00000000 1 0 0badc0de 00000000
R 00000010 00000000 1 0 0badc0de 00000000
R 00000400 00000000 1 0 0badc0de 00000000
R 00000004 00000000 1 0 0badc0de 0badc0de

// ==== files.f ====
hw/exit_pkg.sv
hw/axi_lite_mem_bridge.sv
hw/exit_decoder.sv
hw/exit_status.sv
hw/exit_device_top.sv
tests/tb_exit_device.sv
